//--- Makefile
# Verilator build and run for the execute stage testbench

VERILATOR  ?= verilator
TOP        ?= tb_exe_stage
FILELIST   ?= exe_stage.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
PASS_TEXT  ?= SIMULATION PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- exe_agu.sv
module exe_agu (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               mem_rd,
  input  logic               mem_wr,
  input  exe_pkg::word_t     addr,
  input  exe_pkg::mem_size_t mem_size,
  input  logic               mem_unsigned,
  input  exe_pkg::word_t     store_data,
  output logic               dmem_req,
  output logic               dmem_we,
  output exe_pkg::word_t     dmem_addr,
  output exe_pkg::strb_t     dmem_strb,
  output exe_pkg::word_t     dmem_wdata,
  input  logic               dmem_addr_ok,
  input  logic               dmem_data_ok,
  input  exe_pkg::word_t     dmem_rdata,
  output exe_pkg::word_t     load_data,
  output logic               mem_done,
  output logic               excp_ale
);
  import exe_pkg::*;

  agu_state_t state;
  agu_state_t state_next;

  // byte offset in bits
  logic [4:0] lane_shift;
  assign lane_shift = {addr[1:0], 3'b000};

  // alignment check, bytes never fault
  logic misaligned;
  always_comb begin
    case (mem_size)
      size_half: misaligned = addr[0];
      size_word: misaligned = addr[1] | addr[0];
      default:   misaligned = 1'b0;
    endcase
  end

  assign excp_ale = (mem_rd | mem_wr) & misaligned;

  // byte lanes touched by the access
  always_comb begin
    case (mem_size)
      size_byte: dmem_strb = strb_t'(4'b0001 << addr[1:0]);
      size_half: dmem_strb = addr[1] ? 4'b1100 : 4'b0011;
      size_word: dmem_strb = 4'b1111;
      default:   dmem_strb = 4'b0000;
    endcase
  end

  // store data moved up to its lane
  assign dmem_wdata = store_data << lane_shift;
  assign dmem_addr  = addr;
  assign dmem_we    = mem_wr;

  // request while idle with a legal access, or still waiting on acceptance
  assign dmem_req = ((state == agu_idle) & (mem_rd | mem_wr) & ~misaligned)
                  | (state == agu_wait_addr)
                  | (state == agu_wait_store);

  // read word shifted down, then extended
  word_t rdata_shifted;
  assign rdata_shifted = dmem_rdata >> lane_shift;

  always_comb begin
    case (mem_size)
      size_byte: begin
        load_data = {{24{rdata_shifted[7] & ~mem_unsigned}}, rdata_shifted[7:0]};
      end
      size_half: begin
        load_data = {{16{rdata_shifted[15] & ~mem_unsigned}}, rdata_shifted[15:0]};
      end
      default: begin
        load_data = rdata_shifted;
      end
    endcase
  end

  // store ends at acceptance, load on read-data valid
  logic store_accept;
  logic load_return;

  assign store_accept = dmem_req & dmem_we & dmem_addr_ok;
  assign load_return  = (state == agu_wait_data) & dmem_data_ok;
  assign mem_done     = excp_ale | store_accept | load_return;

  always_comb begin
    state_next = state;
    case (state)
      agu_idle: begin
        if (mem_rd & ~misaligned) begin
          state_next = dmem_addr_ok ? agu_wait_data : agu_wait_addr;
        end else if (mem_wr & ~misaligned) begin
          // accepted store needs no further wait
          state_next = dmem_addr_ok ? agu_idle : agu_wait_store;
        end
      end
      agu_wait_addr: begin
        if (dmem_addr_ok) begin
          state_next = agu_wait_data;
        end
      end
      agu_wait_data: begin
        if (dmem_data_ok) begin
          state_next = agu_idle;
        end
      end
      agu_wait_store: begin
        if (dmem_addr_ok) begin
          state_next = agu_idle;
        end
      end
      default: begin
        state_next = agu_idle;
      end
    endcase
    // a faulting access never leaves idle
    if (excp_ale) begin
      state_next = agu_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= agu_idle;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- exe_alu.sv
module exe_alu (
  input  exe_pkg::alu_op_t alu_op,
  input  exe_pkg::word_t   src1,
  input  exe_pkg::word_t   src2,
  output exe_pkg::word_t   result,
  output logic             zero,
  output logic             less
);
  import exe_pkg::*;

  // one-hot select bits
  logic op_add;
  logic op_sub;
  logic op_slt;
  logic op_sltu;
  logic op_and;
  logic op_nor;
  logic op_or;
  logic op_xor;
  logic op_sll;
  logic op_srl;
  logic op_sra;
  logic op_lui;

  assign op_add  = alu_op[alu_add];
  assign op_sub  = alu_op[alu_sub];
  assign op_slt  = alu_op[alu_slt];
  assign op_sltu = alu_op[alu_sltu];
  assign op_and  = alu_op[alu_and];
  assign op_nor  = alu_op[alu_nor];
  assign op_or   = alu_op[alu_or];
  assign op_xor  = alu_op[alu_xor];
  assign op_sll  = alu_op[alu_sll];
  assign op_srl  = alu_op[alu_srl];
  assign op_sra  = alu_op[alu_sra];
  assign op_lui  = alu_op[alu_lui];

  // shared adder, subtract as src1 + ~src2 + 1
  logic  do_sub;
  word_t adder_b;
  word_t adder_sum;
  logic  adder_cout;

  assign do_sub  = op_sub | op_slt | op_sltu;
  assign adder_b = do_sub ? ~src2 : src2;
  assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b} + {{xlen{1'b0}}, do_sub};

  // signed less: operand signs differ, else sign of the difference
  logic slt_bit;
  assign slt_bit = (src1[xlen-1] & ~src2[xlen-1])
                 | (~(src1[xlen-1] ^ src2[xlen-1]) & adder_sum[xlen-1]);

  // unsigned less, no carry out means a borrow
  logic sltu_bit;
  assign sltu_bit = ~adder_cout;

  // shifts
  shamt_t shamt;
  word_t  sll_res;
  word_t  srl_res;
  word_t  sra_res;

  assign shamt   = src2[4:0];
  assign sll_res = src1 << shamt;
  assign srl_res = src1 >> shamt;
  // sign fill from src1 msb
  assign sra_res = word_t'($signed(src1) >>> shamt);

  // and-or result mux
  assign result = ({xlen{op_add | op_sub}} & adder_sum)
                | ({xlen{op_slt}}          & {{(xlen-1){1'b0}}, slt_bit})
                | ({xlen{op_sltu}}         & {{(xlen-1){1'b0}}, sltu_bit})
                | ({xlen{op_and}}          & (src1 & src2))
                | ({xlen{op_nor}}          & ~(src1 | src2))
                | ({xlen{op_or}}           & (src1 | src2))
                | ({xlen{op_xor}}          & (src1 ^ src2))
                | ({xlen{op_sll}}          & sll_res)
                | ({xlen{op_srl}}          & srl_res)
                | ({xlen{op_sra}}          & sra_res)
                | ({xlen{op_lui}}          & src2);

  // flags for the branch unit
  // zero for eq/ne via sub, less for lt/ge via slt
  assign zero = ~(|result);
  assign less = result[0];

endmodule

//--- exe_branch.sv
module exe_branch (
  input  exe_pkg::br_cond_t br_cond,
  input  logic              br_rel_rj,
  input  logic              pred_taken,
  input  logic              zero,
  input  logic              less,
  input  exe_pkg::word_t    pc,
  input  exe_pkg::word_t    rj_value,
  input  exe_pkg::word_t    imm,
  output exe_pkg::word_t    redirect_pc,
  output logic              mispredict,
  output exe_pkg::word_t    link_pc
);
  import exe_pkg::*;

  // condition from alu flags
  logic taken;

  always_comb begin
    case (br_cond)
      br_always: taken = 1'b1;
      br_eq:     taken = zero;
      br_ne:     taken = ~zero;
      br_lt:     taken = less;
      br_ge:     taken = ~less;
      default:   taken = 1'b0;
    endcase
  end

  // target base is rj for jirl-style, else pc
  word_t base;
  word_t target;

  assign base   = br_rel_rj ? rj_value : pc;
  // offset is in words
  assign target = base + (imm << 2);

  // next sequential pc, also the link value
  assign link_pc = pc + inst_bytes;

  // where fetch should go once resolved
  assign redirect_pc = taken ? target : link_pc;

  // prediction check
  assign mispredict = taken ^ pred_taken;

endmodule

//--- exe_muldiv.sv
module exe_muldiv (
  input  exe_pkg::md_op_t md_op,
  input  exe_pkg::word_t  src1,
  input  exe_pkg::word_t  src2,
  output exe_pkg::word_t  result
);
  import exe_pkg::*;

  // full-width products
  logic signed [2*xlen-1:0] prod_s;
  logic        [2*xlen-1:0] prod_u;

  // sign-extend first so the 64-bit product is exact
  assign prod_s = $signed({{xlen{src1[xlen-1]}}, src1})
                * $signed({{xlen{src2[xlen-1]}}, src2});
  // zero-extend for the unsigned high word
  assign prod_u = {{xlen{1'b0}}, src1} * {{xlen{1'b0}}, src2};

  // signed divide truncates toward zero
  // remainder follows the dividend sign
  logic signed [xlen-1:0] quot_s;
  logic signed [xlen-1:0] rem_s;

  assign quot_s = $signed(src1) / $signed(src2);
  assign rem_s  = $signed(src1) % $signed(src2);

  // unsigned divide
  word_t quot_u;
  word_t rem_u;

  assign quot_u = src1 / src2;
  assign rem_u  = src1 % src2;

  // pick the word asked for
  always_comb begin
    case (md_op)
      md_mul: begin
        result = prod_s[xlen-1:0];
      end
      md_mulh: begin
        result = prod_s[2*xlen-1:xlen];
      end
      md_mulhu: begin
        result = prod_u[2*xlen-1:xlen];
      end
      md_div: begin
        result = quot_s;
      end
      md_divu: begin
        result = quot_u;
      end
      md_mod: begin
        result = rem_s;
      end
      md_modu: begin
        result = rem_u;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- exe_pkg.sv
package exe_pkg;

  // datapath width
  localparam int xlen = 32;

  // data or address word
  typedef logic [xlen-1:0] word_t;

  // one-hot alu select, bit index per operation
  localparam int alu_ops = 12;
  typedef logic [alu_ops-1:0] alu_op_t;

  localparam int alu_add  = 0;
  localparam int alu_sub  = 1;
  localparam int alu_slt  = 2;
  localparam int alu_sltu = 3;
  localparam int alu_and  = 4;
  localparam int alu_nor  = 5;
  localparam int alu_or   = 6;
  localparam int alu_xor  = 7;
  localparam int alu_sll  = 8;
  localparam int alu_srl  = 9;
  localparam int alu_sra  = 10;
  localparam int alu_lui  = 11;

  // shift amount, low five bits of src2
  typedef logic [4:0] shamt_t;

  // byte write enables, one per lane
  typedef logic [3:0] strb_t;

  // unit that owns the result
  typedef enum logic [2:0] {
    fu_alu,
    fu_mul,
    fu_div,
    fu_load,
    fu_store,
    fu_branch
  } fu_sel_t;

  // mul/div flavours
  typedef enum logic [2:0] {
    md_mul,
    md_mulh,
    md_mulhu,
    md_div,
    md_divu,
    md_mod,
    md_modu
  } md_op_t;

  // access width
  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word
  } mem_size_t;

  // branch conditions, flags come from the alu
  typedef enum logic [2:0] {
    br_always,
    br_eq,
    br_ne,
    br_lt,
    br_ge
  } br_cond_t;

  // load/store handshake states
  typedef enum logic [1:0] {
    agu_idle,
    agu_wait_addr,
    agu_wait_data,
    agu_wait_store
  } agu_state_t;

  // fall-through step
  localparam word_t inst_bytes = 32'd4;

endpackage

//--- exe_stage.f
exe_pkg.sv
exe_alu.sv
exe_muldiv.sv
exe_branch.sv
exe_agu.sv
exe_stage.sv
tb_dcache_model.sv
tb_exe_stage.sv

//--- exe_stage.sv
module exe_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  exe_pkg::fu_sel_t   fu_sel,
  input  exe_pkg::alu_op_t   alu_op,
  input  exe_pkg::md_op_t    md_op,
  input  exe_pkg::mem_size_t mem_size,
  input  logic               mem_unsigned,
  input  exe_pkg::br_cond_t  br_cond,
  input  logic               br_rel_rj,
  input  logic               pred_taken,
  input  exe_pkg::word_t     pc,
  input  exe_pkg::word_t     src1,
  input  exe_pkg::word_t     src2,
  input  exe_pkg::word_t     imm,
  input  exe_pkg::word_t     store_data,
  output exe_pkg::word_t     result,
  output logic               done,
  output exe_pkg::word_t     redirect_pc,
  output logic               mispredict,
  output logic               excp_ale,
  output logic               dmem_req,
  output logic               dmem_we,
  output exe_pkg::word_t     dmem_addr,
  output exe_pkg::strb_t     dmem_strb,
  output exe_pkg::word_t     dmem_wdata,
  input  logic               dmem_addr_ok,
  input  logic               dmem_data_ok,
  input  exe_pkg::word_t     dmem_rdata
);
  import exe_pkg::*;

  word_t alu_result;
  word_t md_result;
  word_t load_data;
  word_t link_pc;
  word_t mem_addr;
  logic  alu_zero;
  logic  alu_less;
  logic  br_mispredict;
  logic  mem_done;
  logic  mem_rd;
  logic  mem_wr;
  logic  is_mem;

  // memory ops only start with a valid op
  assign mem_rd   = in_valid & (fu_sel == fu_load);
  assign mem_wr   = in_valid & (fu_sel == fu_store);
  assign is_mem   = (fu_sel == fu_load) | (fu_sel == fu_store);
  // base plus offset
  assign mem_addr = src1 + imm;

  // also computes the compare for branches
  exe_alu u_alu (
    .alu_op (alu_op),
    .src1   (src1),
    .src2   (src2),
    .result (alu_result),
    .zero   (alu_zero),
    .less   (alu_less)
  );

  exe_muldiv u_muldiv (
    .md_op  (md_op),
    .src1   (src1),
    .src2   (src2),
    .result (md_result)
  );

  exe_branch u_branch (
    .br_cond     (br_cond),
    .br_rel_rj   (br_rel_rj),
    .pred_taken  (pred_taken),
    .zero        (alu_zero),
    .less        (alu_less),
    .pc          (pc),
    .rj_value    (src1),
    .imm         (imm),
    .redirect_pc (redirect_pc),
    .mispredict  (br_mispredict),
    .link_pc     (link_pc)
  );

  exe_agu u_agu (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_rd       (mem_rd),
    .mem_wr       (mem_wr),
    .addr         (mem_addr),
    .mem_size     (mem_size),
    .mem_unsigned (mem_unsigned),
    .store_data   (store_data),
    .dmem_req     (dmem_req),
    .dmem_we      (dmem_we),
    .dmem_addr    (dmem_addr),
    .dmem_strb    (dmem_strb),
    .dmem_wdata   (dmem_wdata),
    .dmem_addr_ok (dmem_addr_ok),
    .dmem_data_ok (dmem_data_ok),
    .dmem_rdata   (dmem_rdata),
    .load_data    (load_data),
    .mem_done     (mem_done),
    .excp_ale     (excp_ale)
  );

  // result by owning unit, stores write nothing back
  always_comb begin
    case (fu_sel)
      fu_alu:    result = alu_result;
      fu_mul:    result = md_result;
      fu_div:    result = md_result;
      fu_load:   result = load_data;
      fu_branch: result = link_pc;
      default:   result = '0;
    endcase
  end

  // zero latency except memory
  assign done       = in_valid & (is_mem ? mem_done : 1'b1);
  // only a real branch can mispredict
  assign mispredict = in_valid & (fu_sel == fu_branch) & br_mispredict;

endmodule

//--- tb_dcache_model.sv
module tb_dcache_model (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           dmem_req,
  input  logic           dmem_we,
  input  exe_pkg::word_t dmem_addr,
  input  exe_pkg::strb_t dmem_strb,
  input  exe_pkg::word_t dmem_wdata,
  input  logic           excp_ale,
  output logic           dmem_addr_ok,
  output logic           dmem_data_ok,
  output exe_pkg::word_t dmem_rdata,
  output logic           req_on_ale
);
  timeunit 1ns;
  timeprecision 1ps;
  import exe_pkg::*;

  localparam int words = 16;

  word_t       mem [words];
  int          seed = 32'hfc152bdb;
  int unsigned addr_delay;
  int unsigned addr_wait;
  int unsigned data_left;
  logic        load_busy;
  word_t       read_word;

  // uniform delay in lo..hi cycles
  function automatic int unsigned pick_delay(input int unsigned lo, input int unsigned hi);
    return lo + ({$random(seed)} % (hi - lo + 1));
  endfunction

  // accept once the drawn number of request cycles has gone by
  assign dmem_addr_ok = dmem_req & ~load_busy & (addr_wait >= addr_delay);
  // read data comes back data_left cycles after acceptance
  assign dmem_data_ok = load_busy & (data_left == 1);
  assign dmem_rdata   = read_word;

  always @(posedge clk) begin
    if (!rst_n) begin
      // fill pattern tied to the full byte address
      for (int i = 0; i < words; i++) begin
        mem[i] <= {~16'(i * 4), 16'(i * 4)};
      end
      addr_wait  <= 0;
      addr_delay <= pick_delay(0, 3);
      data_left  <= 0;
      load_busy  <= 1'b0;
      read_word  <= '0;
      req_on_ale <= 1'b0;
    end else begin
      // a faulting access must never reach the cache
      if (dmem_req & excp_ale) begin
        req_on_ale <= 1'b1;
      end
      if (dmem_addr_ok) begin
        addr_wait  <= 0;
        addr_delay <= pick_delay(0, 3);
        if (dmem_we) begin
          for (int b = 0; b < 4; b++) begin
            if (dmem_strb[b]) begin
              mem[dmem_addr[5:2]][8 * b +: 8] <= dmem_wdata[8 * b +: 8];
            end
          end
        end else begin
          read_word <= mem[dmem_addr[5:2]];
          load_busy <= 1'b1;
          data_left <= pick_delay(1, 3);
        end
      end else if (dmem_req) begin
        addr_wait <= addr_wait + 1;
      end
      // one load outstanding at most
      if (dmem_data_ok) begin
        load_busy <= 1'b0;
        data_left <= 0;
      end else if (load_busy) begin
        data_left <= data_left - 1;
      end
    end
  end

endmodule

//--- tb_exe_stage.sv
module tb_exe_stage;
  timeunit 1ns;
  timeprecision 1ps;
  import exe_pkg::*;

  localparam int clk_period       = 40;
  localparam int reset_cycles     = 10;
  localparam int cycles_per_entry = 10;

  // one operation plus what should come back
  typedef struct {
    fu_sel_t   fu;
    alu_op_t   alu_op;
    md_op_t    md_op;
    mem_size_t size;
    logic      uns;
    br_cond_t  cond;
    logic      rel_rj;
    logic      pred;
    word_t     pc;
    word_t     src1;
    word_t     src2;
    word_t     imm;
    word_t     sdata;
    logic      chk_result;
    logic      chk_redirect;
    word_t     exp_result;
    word_t     exp_redirect;
    logic      exp_mispredict;
    logic      exp_ale;
  } entry_t;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      in_valid;
  fu_sel_t   fu_sel;
  alu_op_t   alu_op;
  md_op_t    md_op;
  mem_size_t mem_size;
  logic      mem_unsigned;
  br_cond_t  br_cond;
  logic      br_rel_rj;
  logic      pred_taken;
  word_t     pc;
  word_t     src1;
  word_t     src2;
  word_t     imm;
  word_t     store_data;
  word_t     result;
  logic      done;
  word_t     redirect_pc;
  logic      mispredict;
  logic      excp_ale;
  logic      dmem_req;
  logic      dmem_we;
  word_t     dmem_addr;
  strb_t     dmem_strb;
  word_t     dmem_wdata;
  logic      dmem_addr_ok;
  logic      dmem_data_ok;
  word_t     dmem_rdata;
  logic      req_on_ale;

  entry_t entries[$];
  // expected memory contents as stores are queued
  word_t  shadow [16];
  int     checks;
  int     errors;
  int     cycle_count;
  int     cycle_limit;
  logic   ale_req_seen;

  always #(clk_period / 2) clk = ~clk;

  exe_stage u_exe_stage (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .fu_sel(fu_sel), .alu_op(alu_op),
    .md_op(md_op), .mem_size(mem_size), .mem_unsigned(mem_unsigned), .br_cond(br_cond),
    .br_rel_rj(br_rel_rj), .pred_taken(pred_taken), .pc(pc), .src1(src1), .src2(src2),
    .imm(imm), .store_data(store_data), .result(result), .done(done),
    .redirect_pc(redirect_pc), .mispredict(mispredict), .excp_ale(excp_ale),
    .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_strb(dmem_strb),
    .dmem_wdata(dmem_wdata), .dmem_addr_ok(dmem_addr_ok), .dmem_data_ok(dmem_data_ok),
    .dmem_rdata(dmem_rdata)
  );

  tb_dcache_model u_dcache (
    .clk(clk), .rst_n(rst_n), .dmem_req(dmem_req), .dmem_we(dmem_we),
    .dmem_addr(dmem_addr), .dmem_strb(dmem_strb), .dmem_wdata(dmem_wdata),
    .excp_ale(excp_ale), .dmem_addr_ok(dmem_addr_ok), .dmem_data_ok(dmem_data_ok),
    .dmem_rdata(dmem_rdata), .req_on_ale(req_on_ale)
  );

  // stop a run that stops making progress
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("run stopped after %0d cycles without finishing the tests", cycle_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic check_word(input string sig, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got %h expected %h", sig, got, exp);
    end
  endtask

  task automatic check_bit(input string sig, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got %h expected %h", sig, got, exp);
    end
  endtask

  // byte lanes written by a store of the given size
  function automatic word_t merge_store(input word_t old, input word_t addr,
                                       input mem_size_t size, input word_t data);
    word_t w;
    int    off;
    int    nbytes;
    w      = old;
    off    = int'(addr[1:0]);
    nbytes = (size == size_byte) ? 1 : (size == size_half) ? 2 : 4;
    for (int k = 0; k < nbytes; k++) begin
      w[8 * (off + k) +: 8] = data[8 * k +: 8];
    end
    return w;
  endfunction

  // pick the addressed lanes, then sign or zero extend
  function automatic word_t extract_load(input word_t w, input word_t addr,
                                         input mem_size_t size, input logic uns);
    int          off;
    logic [7:0]  b;
    logic [15:0] h;
    off = int'(addr[1:0]);
    b   = w[8 * off +: 8];
    h   = w[8 * off +: 16];
    case (size)
      size_byte: return uns ? {24'h0, b} : {{24{b[7]}}, b};
      size_half: return uns ? {16'h0, h} : {{16{h[15]}}, h};
      default:   return w;
    endcase
  endfunction

  function automatic entry_t blank_entry(input fu_sel_t fu);
    entry_t e;
    e = '{fu: fu, alu_op: alu_op_t'(1) << alu_add, md_op: md_mul, size: size_word,
          cond: br_always, chk_result: 1'b1, default: '0};
    return e;
  endfunction

  task automatic alu_case(input int op_bit, input word_t a, input word_t b, input word_t exp);
    entry_t e;
    e            = blank_entry(fu_alu);
    e.alu_op     = alu_op_t'(1) << op_bit;
    e.src1       = a;
    e.src2       = b;
    e.exp_result = exp;
    entries.push_back(e);
  endtask

  task automatic md_case(input fu_sel_t fu, input md_op_t op, input word_t a, input word_t b,
                         input word_t exp);
    entry_t e;
    e            = blank_entry(fu);
    e.md_op      = op;
    e.src1       = a;
    e.src2       = b;
    e.exp_result = exp;
    entries.push_back(e);
  endtask

  // expected result is the link address at pc plus one instruction
  task automatic branch_case(input br_cond_t cond, input logic rel_rj, input logic pred,
                             input word_t pc_v, input word_t rj, input word_t rk,
                             input word_t off, input word_t exp_pc, input logic exp_mp);
    entry_t e;
    e                = blank_entry(fu_branch);
    e.cond           = cond;
    // eq/ne compare by subtract, lt/ge by signed less
    e.alu_op         = alu_op_t'(1) << ((cond == br_eq || cond == br_ne) ? alu_sub :
                                        (cond == br_always) ? alu_add : alu_slt);
    e.rel_rj         = rel_rj;
    e.pred           = pred;
    e.pc             = pc_v;
    e.src1           = rj;
    e.src2           = rk;
    e.imm            = off;
    e.chk_redirect   = 1'b1;
    e.exp_result     = pc_v + 32'd4;
    e.exp_redirect   = exp_pc;
    e.exp_mispredict = exp_mp;
    entries.push_back(e);
  endtask

  task automatic store_case(input mem_size_t size, input word_t base, input word_t off,
                            input word_t data);
    entry_t e;
    word_t  addr;
    addr               = base + off;
    e                  = blank_entry(fu_store);
    e.size             = size;
    e.src1             = base;
    e.imm              = off;
    e.sdata            = data;
    shadow[addr[5:2]]  = merge_store(shadow[addr[5:2]], addr, size, data);
    entries.push_back(e);
  endtask

  task automatic load_case(input mem_size_t size, input logic uns, input word_t base,
                           input word_t off);
    entry_t e;
    word_t  addr;
    addr         = base + off;
    e            = blank_entry(fu_load);
    e.size       = size;
    e.uns        = uns;
    e.src1       = base;
    e.imm        = off;
    e.exp_result = extract_load(shadow[addr[5:2]], addr, size, uns);
    entries.push_back(e);
  endtask

  // no result, no request, memory untouched
  task automatic misalign_case(input fu_sel_t fu, input mem_size_t size, input word_t base,
                               input word_t off);
    entry_t e;
    e            = blank_entry(fu);
    e.size       = size;
    e.src1       = base;
    e.imm        = off;
    e.sdata      = 32'hbad0bad0;
    e.chk_result = 1'b0;
    e.exp_ale    = 1'b1;
    entries.push_back(e);
  endtask

  task automatic build_table();
    foreach (shadow[i]) begin
      shadow[i] = '0;
    end
    alu_case(alu_add, 32'h00000005, 32'h00000007, 32'h0000000c);
    alu_case(alu_add, 32'hffffffff, 32'h00000002, 32'h00000001);
    alu_case(alu_sub, 32'h00000000, 32'h00000001, 32'hffffffff);
    alu_case(alu_slt, 32'h80000000, 32'h00000001, 32'h00000001);
    alu_case(alu_sltu, 32'h80000000, 32'h00000001, 32'h00000000);
    alu_case(alu_and, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000);
    alu_case(alu_nor, 32'h0f0f0000, 32'h000000f0, 32'hf0f0ff0f);
    alu_case(alu_or, 32'h12340000, 32'h00005678, 32'h12345678);
    alu_case(alu_xor, 32'hffff0000, 32'h0ff00ff0, 32'hf00f0ff0);
    // only the low five bits of src2 count
    alu_case(alu_sll, 32'h12345678, 32'h00000024, 32'h23456780);
    alu_case(alu_srl, 32'h80000000, 32'h00000004, 32'h08000000);
    alu_case(alu_sra, 32'h80000000, 32'h00000004, 32'hf8000000);
    alu_case(alu_sra, 32'h7fff0000, 32'h00000008, 32'h007fff00);
    alu_case(alu_lui, 32'h11111111, 32'habcde000, 32'habcde000);
    md_case(fu_mul, md_mul, 32'h00000007, 32'hfffffffd, 32'hffffffeb);
    md_case(fu_mul, md_mulh, 32'h80000000, 32'h80000000, 32'h40000000);
    md_case(fu_mul, md_mulh, 32'hffffffff, 32'h00000005, 32'hffffffff);
    md_case(fu_mul, md_mulhu, 32'hffffffff, 32'hffffffff, 32'hfffffffe);
    md_case(fu_mul, md_mulhu, 32'h80000000, 32'h00000004, 32'h00000002);
    // signed divide rounds toward zero
    md_case(fu_div, md_div, 32'hfffffff9, 32'h00000002, 32'hfffffffd);
    md_case(fu_div, md_mod, 32'hfffffff9, 32'h00000002, 32'hffffffff);
    md_case(fu_div, md_div, 32'h00000007, 32'hfffffffe, 32'hfffffffd);
    md_case(fu_div, md_mod, 32'h00000007, 32'hfffffffe, 32'h00000001);
    md_case(fu_div, md_divu, 32'hfffffff9, 32'h00000002, 32'h7ffffffc);
    md_case(fu_div, md_modu, 32'hfffffff9, 32'h00000002, 32'h00000001);
    branch_case(br_eq, 0, 0, 32'h1000, 32'h5, 32'h5, 32'h4, 32'h1010, 1);
    branch_case(br_eq, 0, 0, 32'h1000, 32'h5, 32'h6, 32'h4, 32'h1004, 0);
    branch_case(br_ne, 0, 1, 32'h1000, 32'h1, 32'h2, 32'hfffffffe, 32'h0ff8, 0);
    branch_case(br_lt, 0, 0, 32'h1000, 32'hffffffff, 32'h1, 32'h8, 32'h1020, 1);
    branch_case(br_ge, 0, 1, 32'h1000, 32'h1, 32'hffffffff, 32'h2, 32'h1008, 0);
    branch_case(br_ge, 0, 1, 32'h1000, 32'h80000000, 32'h1, 32'h2, 32'h1004, 1);
    branch_case(br_always, 1, 0, 32'h1000, 32'h2000, 32'h0, 32'h3, 32'h200c, 1);
    branch_case(br_always, 0, 1, 32'h3000, 32'h0, 32'h0, 32'hfffffc00, 32'h2000, 0);
    // full words first so every loaded byte is known
    store_case(size_word, 32'h08, 32'h08, 32'h12345678);
    store_case(size_word, 32'h14, 32'h00, 32'h00000000);
    store_case(size_byte, 32'h20, 32'hfffffff1, 32'hdeadbef5);
    store_case(size_half, 32'h10, 32'h06, 32'h55558001);
    store_case(size_byte, 32'h14, 32'h00, 32'h1234567f);
    load_case(size_byte, 0, 32'h10, 32'h01);
    load_case(size_byte, 1, 32'h10, 32'h01);
    load_case(size_byte, 0, 32'h10, 32'h00);
    load_case(size_byte, 0, 32'h10, 32'h03);
    load_case(size_byte, 1, 32'h14, 32'h00);
    load_case(size_half, 0, 32'h20, 32'hfffffff6);
    load_case(size_half, 1, 32'h16, 32'h00);
    load_case(size_half, 0, 32'h10, 32'h02);
    load_case(size_word, 0, 32'h10, 32'h00);
    load_case(size_word, 0, 32'h0c, 32'h08);
    misalign_case(fu_load, size_half, 32'h10, 32'h01);
    misalign_case(fu_load, size_word, 32'h10, 32'h02);
    misalign_case(fu_store, size_word, 32'h10, 32'h03);
    misalign_case(fu_store, size_half, 32'h14, 32'h01);
    // memory unchanged by the faulting stores
    load_case(size_word, 0, 32'h10, 32'h00);
    load_case(size_word, 0, 32'h14, 32'h00);
  endtask

  task automatic drive_entry(input entry_t e);
    in_valid     = 1'b1;
    fu_sel       = e.fu;
    alu_op       = e.alu_op;
    md_op        = e.md_op;
    mem_size     = e.size;
    mem_unsigned = e.uns;
    br_cond      = e.cond;
    br_rel_rj    = e.rel_rj;
    pred_taken   = e.pred;
    pc           = e.pc;
    src1         = e.src1;
    src2         = e.src2;
    imm          = e.imm;
    store_data   = e.sdata;
  endtask

  // hold until done, check mid low phase, leave on the next falling edge
  task automatic run_entry(input int idx, input entry_t e);
    int waited;
    int errors_before;
    waited        = 0;
    errors_before = errors;
    drive_entry(e);
    #(clk_period / 4);
    while (done !== 1'b1) begin
      @(negedge clk);
      #(clk_period / 4);
      waited++;
    end
    // faulting accesses finish at once like the combinational units
    if ((e.exp_ale || (e.fu != fu_load && e.fu != fu_store)) && waited != 0) begin
      errors++;
      $display("done came late for an operation that should finish at once");
    end
    if (e.chk_result) begin
      check_word("result", result, e.exp_result);
    end
    if (e.chk_redirect) begin
      check_word("redirect_pc", redirect_pc, e.exp_redirect);
    end
    check_bit("mispredict", mispredict, e.exp_mispredict);
    check_bit("excp_ale", excp_ale, e.exp_ale);
    if (e.exp_ale) begin
      check_bit("dmem_req", dmem_req, 1'b0);
    end
    @(negedge clk);
    if (req_on_ale && !ale_req_seen) begin
      ale_req_seen = 1'b1;
      errors++;
      $display("the cache saw a request while an alignment exception was raised");
    end
    $display("entry %0d %s after %0d wait cycles %s", idx, e.fu.name(), waited,
             (errors == errors_before) ? "ok" : "failed");
  endtask

  initial begin
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    fu_sel       = fu_alu;
    alu_op       = '0;
    md_op        = md_mul;
    mem_size     = size_word;
    mem_unsigned = 1'b0;
    br_cond      = br_always;
    br_rel_rj    = 1'b0;
    pred_taken   = 1'b0;
    pc           = '0;
    src1         = '0;
    src2         = '0;
    imm          = '0;
    store_data   = '0;
    checks       = 0;
    errors       = 0;
    cycle_count  = 0;
    ale_req_seen = 1'b0;
    build_table();
    cycle_limit = entries.size() * cycles_per_entry + reset_cycles;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
    foreach (entries[i]) begin
      run_entry(i, entries[i]);
    end
    in_valid = 1'b0;
    $display("entries %0d checks %0d errors %0d", entries.size(), checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
